// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_video_out -Mdir obj_dir -f all.f
	./obj_dir/Vtb_video_out 2>&1 | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
logic/video_pkg.sv
logic/prom_pkg.sv
logic/palette_prom.sv
logic/prom_loader.sv
logic/video_timing.sv
logic/colour_mixer.sv
logic/video_out_top.sv
sim/tb_video_out.sv

// ==== logic/colour_mixer.sv ====
// looks up the three layer colours, applies text > object > background priority, drives rgb
`timescale 1ns/1ps

module colour_mixer
    import video_pkg::*, prom_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               pxl_cen,
    input  video_timing_t      timing,
    input  layer_codes_t       layers,
    input  logic [2:0]         prom_we,      // from loader, one-hot
    input  logic [PROM_AW-1:0] prom_addr,
    input  colour_t            prom_wdata,
    output rgb_t               rgb
);

    colour_t bak_rgb;
    colour_t obj_rgb;
    colour_t txt_rgb;
    colour_t pick;       // entry of the latched winner
    layer_e  layer_sel;  // aligned with the PROM read registers

    // background
    palette_prom u_prom_bak (
        .clk     (clk),
        .cen     (pxl_cen),
        .we      (prom_we[PROM_BAK]),
        .wr_addr (prom_addr),
        .rd_addr (layers.bakc),
        .wdata   (prom_wdata),
        .q       (bak_rgb)
    );

    // objects, single 8-bit PROM
    palette_prom u_prom_obj (
        .clk     (clk),
        .cen     (pxl_cen),
        .we      (prom_we[PROM_OBJ]),
        .wr_addr (prom_addr),
        .rd_addr (layers.objc),
        .wdata   (prom_wdata),
        .q       (obj_rgb)
    );

    // text
    palette_prom u_prom_txt (
        .clk     (clk),
        .cen     (pxl_cen),
        .we      (prom_we[PROM_TXT]),
        .wr_addr (prom_addr),
        .rd_addr (layers.txtc),
        .wdata   (prom_wdata),
        .q       (txt_rgb)
    );

    // priority latched with the lookup
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            layer_sel <= LAYER_NONE;
        end else if (pxl_cen) begin
            if (!layers.txtv) begin
                layer_sel <= LAYER_TXT;
            end else if (|layers.objv) begin
                layer_sel <= LAYER_OBJ;
            end else if (!timing.hblank && !timing.vblank) begin
                layer_sel <= LAYER_BAK;   // only background gets blanked
            end else begin
                layer_sel <= LAYER_NONE;
            end
        end
    end

    always_comb begin
        case (layer_sel)
            LAYER_TXT: pick = txt_rgb;
            LAYER_OBJ: pick = obj_rgb;
            LAYER_BAK: pick = bak_rgb;
            default:   pick = '0;   // black
        endcase
    end

    // output register, second pixel stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            rgb.red   <= pick.red;
            rgb.green <= pick.green;
            rgb.blue  <= {pick.blue, 1'b0};   // 2 bits stretched to 3
        end
    end

    a_blue_lsb: assert property (@(posedge clk) disable iff (!arst_n) rgb.blue[0] == 1'b0);

endmodule

// ==== logic/palette_prom.sv ====
// 32x8 colour PROM with a host write port and a read register clocked by the pixel enable
`timescale 1ns/1ps

module palette_prom
    import prom_pkg::*, video_pkg::*;
(
    input  logic               clk,
    input  logic               cen,      // pixel enable, read side only
    input  logic               we,
    input  logic [PROM_AW-1:0] wr_addr,
    input  logic [PROM_AW-1:0] rd_addr,
    input  colour_t            wdata,
    output colour_t            q
);

    colour_t mem [PROM_DEPTH];

    // contents start out black until the host stream arrives
    initial begin
        for (int i = 0; i < PROM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // host side, runs at full clock rate
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wdata;
        end
    end

    // pixel side lookup
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];   // holds between enables
        end
    end

endmodule

// ==== logic/prom_loader.sv ====
// splits the host byte stream into sequential writes to the bak, obj and txt colour PROMs
`timescale 1ns/1ps

module prom_loader
    import prom_pkg::*, video_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               prog_start,   // restarts the stream at byte 0
    input  logic               prog_valid,   // one byte per strobe
    input  logic [7:0]         prog_data,
    output logic [2:0]         prom_we,      // one-hot, bit order bak obj txt
    output logic [PROM_AW-1:0] prom_addr,
    output colour_t            prom_wdata,
    output logic               prog_done
);

    localparam int LAST_BYTE = 3 * PROM_DEPTH - 1;   // 95

    loader_state_e state;
    logic [6:0]    byte_cnt;
    prom_sel_e     prom_sel;

    // upper counter bits pick the PROM
    assign prom_sel = prom_sel_e'(byte_cnt[6:5]);

    // control path
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            byte_cnt  <= '0;
            prog_done <= 1'b0;
            prom_we   <= '0;
        end else begin
            prom_we <= '0;   // single-cycle write pulse
            if (prog_start) begin
                state     <= LOAD;
                byte_cnt  <= '0;
                prog_done <= 1'b0;
            end else if (state == LOAD && prog_valid) begin
                prom_we[prom_sel] <= 1'b1;
                byte_cnt          <= byte_cnt + 7'd1;
                if (byte_cnt == 7'(LAST_BYTE)) begin
                    state     <= IDLE;   // text PROM full
                    prog_done <= 1'b1;   // held until next start
                end
            end
        end
    end

    // write payload, follows the enable by construction
    always_ff @(posedge clk) begin
        if (state == LOAD && prog_valid && !prog_start) begin
            prom_addr  <= byte_cnt[PROM_AW-1:0];
            prom_wdata <= colour_t'(prog_data);
        end
    end

    // at most one PROM written per clock
    a_we_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(prom_we));

    // done only after leaving LOAD
    a_done_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !(prog_done && state == LOAD));

endmodule

// ==== logic/prom_pkg.sv ====
// colour PROM geometry and loader encodings, imported by the loader, mixer and PROM blocks
package prom_pkg;

    // each colour PROM holds 32 bytes
    parameter int PROM_DEPTH = 32;
    parameter int PROM_AW    = 5;

    // target PROM, also the bit position in the one-hot write enable
    typedef enum logic [1:0] {
        PROM_BAK,   // stream bytes 0..31
        PROM_OBJ,   // stream bytes 32..63
        PROM_TXT    // stream bytes 64..95
    } prom_sel_e;

    // loader FSM states
    typedef enum logic {
        IDLE,
        LOAD
    } loader_state_e;

endpackage

// ==== logic/video_out_top.sv ====
// colour output stage top, wires timing generator, PROM loader and colour mixer together
`timescale 1ns/1ps

module video_out_top
    import video_pkg::*, prom_pkg::*;
#(
    parameter int h_total   = 384,
    parameter int h_visible = 256,
    parameter int v_total   = 264,
    parameter int v_visible = 224,
    parameter int pxl_div   = 2
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          prog_start,
    input  logic          prog_valid,
    input  logic [7:0]    prog_data,
    input  layer_codes_t  layers,       // sampled on pxl_cen
    output rgb_t          rgb,
    output video_timing_t timing,
    output logic          pxl_cen,
    output logic          prog_done
);

    logic [2:0]         prom_we;
    logic [PROM_AW-1:0] prom_addr;
    colour_t            prom_wdata;

    video_timing #(
        .h_total   (h_total),
        .h_visible (h_visible),
        .v_total   (v_total),
        .v_visible (v_visible),
        .pxl_div   (pxl_div)
    ) u_timing (
        .clk     (clk),
        .arst_n  (arst_n),
        .pxl_cen (pxl_cen),
        .timing  (timing)
    );

    prom_loader u_loader (
        .clk        (clk),
        .arst_n     (arst_n),
        .prog_start (prog_start),
        .prog_valid (prog_valid),
        .prog_data  (prog_data),
        .prom_we    (prom_we),
        .prom_addr  (prom_addr),
        .prom_wdata (prom_wdata),
        .prog_done  (prog_done)
    );

    colour_mixer u_mixer (
        .clk        (clk),
        .arst_n     (arst_n),
        .pxl_cen    (pxl_cen),
        .timing     (timing),
        .layers     (layers),
        .prom_we    (prom_we),
        .prom_addr  (prom_addr),
        .prom_wdata (prom_wdata),
        .rgb        (rgb)
    );

endmodule

// ==== logic/video_pkg.sv ====
// video path types shared by the colour mixer, timing generator and top level; import where needed
package video_pkg;

    // one colour PROM entry, 3-3-2 layout as stored by the host
    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } colour_t;

    // output pixel, blue widened to 3 bits
    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [2:0] blue;   // lsb always zero
    } rgb_t;

    // per-pixel codes from the tile and sprite engines
    typedef struct packed {
        logic [4:0] bakc;   // background colour code
        logic [4:0] objc;   // object colour code
        logic [1:0] objv;   // nonzero -> object pixel present
        logic [4:0] txtc;   // text colour code
        logic       txtv;   // active low text present
    } layer_codes_t;

    // raster position and blanking levels
    typedef struct packed {
        logic [8:0] hcount;
        logic [8:0] vcount;
        logic       hblank;
        logic       vblank;
    } video_timing_t;

    // layer that wins the priority for one pixel
    typedef enum logic [1:0] {
        LAYER_NONE,
        LAYER_TXT,
        LAYER_OBJ,
        LAYER_BAK
    } layer_e;

endpackage

// ==== logic/video_timing.sv ====
// pixel enable divider plus raster counters and blanking levels for the colour output stage
`timescale 1ns/1ps

module video_timing
    import video_pkg::*;
#(
    parameter int h_total   = 384,
    parameter int h_visible = 256,
    parameter int v_total   = 264,
    parameter int v_visible = 224,
    parameter int pxl_div   = 2      // clocks per pixel, 2 or more
) (
    input  logic          clk,
    input  logic          arst_n,
    output logic          pxl_cen,
    output video_timing_t timing
);

    localparam int DIV_W = $clog2(pxl_div);

    logic [DIV_W-1:0] div_cnt;
    logic [8:0]       h_next;
    logic [8:0]       v_next;

    // clock divider, pulse lands pxl_div clocks after reset release
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= (div_cnt == DIV_W'(pxl_div - 1));
            if (div_cnt == DIV_W'(pxl_div - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // next raster position
    always_comb begin
        h_next = timing.hcount;
        v_next = timing.vcount;
        if (pxl_cen) begin
            if (timing.hcount == 9'(h_total - 1)) begin
                h_next = '0;   // end of line
                if (timing.vcount == 9'(v_total - 1)) begin
                    v_next = '0;   // end of frame
                end else begin
                    v_next = timing.vcount + 9'd1;
                end
            end else begin
                h_next = timing.hcount + 9'd1;
            end
        end
    end

    // blanking derived from next counts so it lines up with them
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            timing <= '0;
        end else begin
            timing.hcount <= h_next;
            timing.vcount <= v_next;
            timing.hblank <= (h_next >= 9'(h_visible));
            timing.vblank <= (v_next >= 9'(v_visible));
        end
    end

    a_h_range: assert property (@(posedge clk) disable iff (!arst_n)
        timing.hcount < 9'(h_total));

endmodule

// ==== sim/tb_video_out.sv ====
// testbench for the colour output stage, loads random palettes then checks timing and pixels
`timescale 1ns/1ps

module tb_video_out
    import video_pkg::*;
();

    localparam int H_TOT = 40;
    localparam int H_VIS = 32;
    localparam int V_TOT = 12;
    localparam int V_VIS = 8;
    localparam int FRAME_CLKS = 2 * H_TOT * V_TOT;   // two clocks per pixel

    logic          clk = 1'b0;
    logic          arst_n;
    logic          prog_start;
    logic          prog_valid;
    logic [7:0]    prog_data;
    layer_codes_t  layers = '0;
    rgb_t          rgb;
    video_timing_t timing;
    logic          pxl_cen;
    logic          prog_done;

    logic [7:0] shadow [96] = '{default: 8'h00};   // bak 0..31, obj 32..63, txt 64..95
    logic [9:0] exp_q [$];        // {check, rgb} per pixel in flight
    logic       model_ok = 1'b1;  // shadow matches the PROMs
    int         clk_edges = 0;    // posedges since reset release
    int         h_cnt = 0;
    int         v_cnt = 0;

    video_out_top #(
        .h_total   (H_TOT),
        .h_visible (H_VIS),
        .v_total   (V_TOT),
        .v_visible (V_VIS),
        .pxl_div   (2)
    ) DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .prog_start (prog_start),
        .prog_valid (prog_valid),
        .prog_data  (prog_data),
        .layers     (layers),
        .rgb        (rgb),
        .timing     (timing),
        .pxl_cen    (pxl_cen),
        .prog_done  (prog_done)
    );

    always #20 clk = ~clk;   // 40 ns period

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clk_edges <= 0;
        end else begin
            clk_edges <= clk_edges + 1;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    // winner by text > object > background, bak only outside blanking
    function automatic logic [8:0] expected_rgb(input layer_codes_t l, input logic blank);
        logic [7:0] e;
        if (!l.txtv) begin
            e = shadow[{2'b10, l.txtc}];
        end else if (l.objv != 2'b00) begin
            e = shadow[{2'b01, l.objc}];
        end else if (!blank) begin
            e = shadow[{2'b00, l.bakc}];
        end else begin
            e = 8'h00;   // black
        end
        return {e, 1'b0};   // 3-3-2 to 3-3-3, blue lsb zero
    endfunction

    // timing and pixel model, all outputs stable at the falling edge
    always @(negedge clk) begin : pixel_model
        logic [9:0] head;
        logic       blank;
        if (clk_edges != 0) begin
            assert (pxl_cen == !clk_edges[0]) else fail_run($sformatf(
                "Mismatch at %0t: pxl_cen expected %b got %b", $time, !clk_edges[0], pxl_cen));
            assert (int'(timing.hcount) == h_cnt) else fail_run($sformatf(
                "Mismatch at %0t: hcount expected %0d got %0d", $time, h_cnt, timing.hcount));
            assert (int'(timing.vcount) == v_cnt) else fail_run($sformatf(
                "Mismatch at %0t: vcount expected %0d got %0d", $time, v_cnt, timing.vcount));
            assert (timing.hblank == (h_cnt >= H_VIS)) else fail_run($sformatf(
                "Mismatch at %0t: hblank expected %b got %b", $time, h_cnt >= H_VIS,
                timing.hblank));
            assert (timing.vblank == (v_cnt >= V_VIS)) else fail_run($sformatf(
                "Mismatch at %0t: vblank expected %b got %b", $time, v_cnt >= V_VIS,
                timing.vblank));
            assert (rgb.blue[0] == 1'b0) else fail_run($sformatf(
                "Mismatch at %0t: rgb blue lsb expected 0 got 1", $time));
            if (pxl_cen) begin
                if (exp_q.size() >= 2) begin
                    head = exp_q.pop_front();
                end else begin
                    head = {1'b1, 9'h000};   // nothing through the pipe yet
                end
                assert (!head[9] || rgb == head[8:0]) else fail_run($sformatf(
                    "Mismatch at %0t: rgb expected %h got %h", $time, head[8:0], rgb));
                layers.bakc = 5'($urandom_range(31));
                layers.objc = 5'($urandom_range(31));
                layers.objv = 2'($urandom_range(3));
                layers.txtc = 5'($urandom_range(31));
                layers.txtv = ($urandom_range(3) != 0);   // text on a quarter of pixels
                blank = (h_cnt >= H_VIS) || (v_cnt >= V_VIS);
                exp_q.push_back({model_ok, expected_rgb(layers, blank)});
                if (h_cnt == H_TOT - 1) begin
                    h_cnt = 0;
                    v_cnt = (v_cnt == V_TOT - 1) ? 0 : v_cnt + 1;
                end else begin
                    h_cnt = h_cnt + 1;
                end
            end
        end
    end

    // done holds until the next start
    a_done_hold: assert property (@(posedge clk) disable iff (!arst_n)
        prog_done && !prog_start |=> prog_done)
        else fail_run("prog_done dropped without a new prog_start");

    task automatic send_byte(input logic [7:0] data, input int gap);
        prog_valid = 1'b1;
        prog_data  = data;
        @(negedge clk);
        prog_valid = 1'b0;
        repeat (gap) @(negedge clk);   // idle clocks between strobes
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!prog_done) begin
            @(negedge clk);
            n++;
            if (n > 20) fail_run("timeout waiting for prog_done after the last byte");
        end
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 2 * FRAME_CLKS) fail_run("timeout waiting for the start of a frame");
        end while (!(pxl_cen && timing.hcount == 9'd0 && timing.vcount == 9'd0));
    endtask

    initial begin
        void'($urandom(32'h63854bd6));
        arst_n     = 1'b0;
        prog_start = 1'b0;
        prog_valid = 1'b0;
        prog_data  = 8'h00;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (rgb == '0) else fail_run($sformatf(
            "Mismatch at %0t: rgb expected 000 got %h", $time, rgb));
        assert (!prog_done) else fail_run($sformatf(
            "Mismatch at %0t: prog_done expected 0 got %b", $time, prog_done));
        // loader idle, these must not reach any PROM
        for (int i = 0; i < 4; i++) begin
            send_byte(8'($urandom_range(255)), 0);
        end
        wait_frame_start();
        model_ok   = 1'b0;   // PROMs change under the pixel path
        prog_start = 1'b1;
        @(negedge clk);
        prog_start = 1'b0;
        for (int i = 0; i < 96; i++) begin
            assert (!prog_done) else fail_run($sformatf(
                "Mismatch at %0t: prog_done expected 0 got %b before byte %0d",
                $time, prog_done, i));
            shadow[7'(i)] = 8'($urandom_range(255));
            send_byte(shadow[7'(i)], int'($urandom_range(3)));
        end
        wait_done();
        @(negedge clk);
        model_ok = 1'b1;
        // stray bytes after done, ignored
        for (int i = 0; i < 6; i++) begin
            send_byte(8'($urandom_range(255)), int'($urandom_range(2)));
        end
        repeat (4) wait_frame_start();   // three full frames
        if (prog_done) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            fail_run($sformatf(
                "Mismatch at %0t: prog_done expected 1 got %b at the end of the run",
                $time, prog_done));
        end
    end

endmodule
